//--- logic/fetch_pkg.sv
////////////////////
// fetch front end shared definitions
// widths, bus master state, bus and packet structs
////////////////////

package fetch_pkg;

  //////////////////// widths

  localparam int xlen       = 64;  // address and pc width
  localparam int inst_width = 32;  // one instruction
  localparam int mem_width  = 64;  // one instruction-memory word, two instructions

  localparam int btb_index_bits = 3;                          // 8 entries
  localparam int btb_tag_bits   = xlen - btb_index_bits - 2;  // pc bits above index and [1:0]

  localparam int queue_depth      = 4;  // power of two, pointers wrap on their own
  localparam int queue_ptr_bits   = $clog2(queue_depth);
  localparam int queue_count_bits = $clog2(queue_depth + 1);  // 0 .. queue_depth

  //////////////////// types

  // wishbone read master state
  typedef enum logic {
    idle,      // no cycle, ready for a request
    wait_ack   // cyc/stb up, waiting on the slave
  } wb_state_t;

  typedef struct packed {
    logic            cyc;
    logic            stb;
    logic [xlen-1:0] adr;  // 8-byte aligned
  } wb_req_t;

  typedef struct packed {
    logic                 ack;
    logic [mem_width-1:0] dat;  // valid with ack only
  } wb_rsp_t;

  typedef struct packed {
    logic [xlen-1:0]       pc;
    logic [xlen-1:0]       npc;         // next pc fetch actually followed
    logic [inst_width-1:0] ir;
    logic                  pred_taken;  // npc came from a btb hit
  } fetch_packet_t;

  typedef struct packed {
    logic            branch_valid;  // a branch retires this cycle
    logic            taken;
    logic            mispredict;    // fetch went the wrong way, redirect
    logic [xlen-1:0] pc;
    logic [xlen-1:0] target;
  } retire_t;

  typedef struct packed {
    logic            hit;
    logic [xlen-1:0] target;
  } btb_lookup_t;

endpackage

//--- logic/imem_wb_port.sv
////////////////////
// instruction memory port
// wishbone classic read master, one cycle per fetch request
////////////////////

`timescale 1ns/1ps

module imem_wb_port (
  input  logic                           clock,
  input  logic                           reset,
  input  logic                           fetch_req,   // from if_stage, honored when not busy
  input  logic [fetch_pkg::xlen-1:0]     fetch_addr,
  input  fetch_pkg::wb_rsp_t             wb_rsp,
  output fetch_pkg::wb_req_t             wb_req,
  output logic                           fetch_busy,
  output logic                           fetch_done,  // one-cycle pulse, data valid with it
  output logic [fetch_pkg::mem_width-1:0] fetch_data
);

  fetch_pkg::wb_state_t        state;
  logic [fetch_pkg::xlen-1:0]  adr_q;   // address held for the whole cycle
  logic                        start;   // accept a request this cycle

  // busy also covers the done pulse, the stage is still consuming that word
  assign fetch_busy = (state == fetch_pkg::wait_ack) | fetch_done;
  assign start      = fetch_req & ~fetch_busy;

  // cyc and stb rise and fall together, both straight from the state
  assign wb_req.cyc = (state == fetch_pkg::wait_ack);
  assign wb_req.stb = (state == fetch_pkg::wait_ack);
  assign wb_req.adr = adr_q;

  //////////////////// bus fsm

  always_ff @(posedge clock) begin
    if (reset) begin
      state      <= fetch_pkg::idle;
      fetch_done <= 1'b0;
    end else begin
      fetch_done <= 1'b0;  // default, pulse only
      case (state)
        fetch_pkg::idle: begin
          if (start)
            state <= fetch_pkg::wait_ack;  // stb up on the next cycle
        end
        fetch_pkg::wait_ack: begin
          if (wb_rsp.ack) begin
            state      <= fetch_pkg::idle;  // drop cyc/stb after ack
            fetch_done <= 1'b1;
          end
        end
        default: state <= fetch_pkg::idle;
      endcase
    end
  end

  // payload registers, no reset needed
  always_ff @(posedge clock) begin
    if (start)
      adr_q <= fetch_addr;
    if ((state == fetch_pkg::wait_ack) && wb_rsp.ack)
      fetch_data <= wb_rsp.dat;  // capture in the ack cycle
  end

endmodule

//--- logic/if_stage.sv
////////////////////
// fetch stage
// pc register, next-pc select, stale return drop, packet build
////////////////////

`timescale 1ns/1ps

module if_stage (
  input  logic                            clock,
  input  logic                            reset,
  input  logic                            fetch_busy,
  input  logic                            fetch_done,
  input  logic [fetch_pkg::mem_width-1:0] fetch_data,
  input  logic                            queue_space,  // two or more entries free
  input  fetch_pkg::btb_lookup_t          btb,
  input  fetch_pkg::retire_t              retire,
  output logic                            fetch_req,
  output logic [fetch_pkg::xlen-1:0]      fetch_addr,
  output logic [fetch_pkg::xlen-1:0]      pc,
  output logic                            push,
  output fetch_pkg::fetch_packet_t        push_packet,
  output logic                            flush
);

  logic                       redirect;     // retire says fetch went wrong
  logic [fetch_pkg::xlen-1:0] redirect_pc;
  logic [fetch_pkg::xlen-1:0] pc_plus_4;
  logic [fetch_pkg::xlen-1:0] follow_pc;    // btb target or sequential
  logic                       stale;        // word in flight belongs to the old stream

  assign redirect    = retire.branch_valid & retire.mispredict;
  assign redirect_pc = retire.taken ? retire.target : retire.pc + 64'd4;  // not taken: fall through
  assign pc_plus_4   = pc + 64'd4;
  assign follow_pc   = btb.hit ? btb.target : pc_plus_4;

  // memory is 64 bits wide, fetch the aligned word holding pc
  assign fetch_addr = {pc[fetch_pkg::xlen-1:3], 3'b000};
  assign fetch_req  = ~fetch_busy & queue_space & ~redirect;
  assign flush      = redirect;

  // a good return: not stale, and no redirect taking over this edge
  assign push = fetch_done & ~stale & ~redirect;

  //////////////////// packet

  assign push_packet.pc         = pc;
  assign push_packet.npc        = follow_pc;
  assign push_packet.ir         = pc[2] ? fetch_data[63:32] : fetch_data[31:0];  // upper half at pc+4
  assign push_packet.pred_taken = btb.hit;

  //////////////////// pc and stale flag

  always_ff @(posedge clock) begin
    if (reset) begin
      pc    <= '0;  // fetch starts at 0
      stale <= 1'b0;
    end else begin
      if (redirect)
        pc <= redirect_pc;        // retire wins over everything
      else if (push)
        pc <= follow_pc;          // advance with the pushed packet

      if (redirect)
        stale <= fetch_busy & ~fetch_done;  // a done word this cycle is simply not pushed
      else if (fetch_done)
        stale <= 1'b0;            // old word dropped, stream clean again
    end
  end

endmodule

//--- logic/branch_target_buffer.sv
////////////////////
// branch target buffer
// direct-mapped, tagged, trained by retiring branches
////////////////////

`timescale 1ns/1ps

module branch_target_buffer (
  input  logic                       clock,
  input  logic                       reset,
  input  logic [fetch_pkg::xlen-1:0] pc,      // registered fetch pc
  input  fetch_pkg::retire_t         retire,
  output fetch_pkg::btb_lookup_t     btb
);

  localparam int entries = 2 ** fetch_pkg::btb_index_bits;

  logic [entries-1:0]                 valid;
  logic [fetch_pkg::btb_tag_bits-1:0] tag_mem    [entries];
  logic [fetch_pkg::xlen-1:0]         target_mem [entries];

  logic [fetch_pkg::btb_index_bits-1:0] rd_index;
  logic [fetch_pkg::btb_tag_bits-1:0]   rd_tag;
  logic [fetch_pkg::btb_index_bits-1:0] wr_index;
  logic [fetch_pkg::btb_tag_bits-1:0]   wr_tag;

  // index sits just above the two low pc bits, tag takes the rest
  assign rd_index = pc[fetch_pkg::btb_index_bits+1:2];
  assign rd_tag   = pc[fetch_pkg::xlen-1:fetch_pkg::btb_index_bits+2];
  assign wr_index = retire.pc[fetch_pkg::btb_index_bits+1:2];
  assign wr_tag   = retire.pc[fetch_pkg::xlen-1:fetch_pkg::btb_index_bits+2];

  //////////////////// lookup

  assign btb.hit    = valid[rd_index] && (tag_mem[rd_index] == rd_tag);
  assign btb.target = target_mem[rd_index];

  //////////////////// retire update

  always_ff @(posedge clock) begin
    if (reset) begin
      valid <= '0;  // all entries empty
    end else if (retire.branch_valid) begin
      if (retire.taken)
        valid[wr_index] <= 1'b1;
      else if (tag_mem[wr_index] == wr_tag)
        valid[wr_index] <= 1'b0;  // not taken any more, forget it
    end
  end

  // tag and target only matter while the entry is valid
  always_ff @(posedge clock) begin
    if (retire.branch_valid && retire.taken) begin
      tag_mem[wr_index]    <= wr_tag;
      target_mem[wr_index] <= retire.target;
    end
  end

endmodule

//--- logic/fetch_queue.sv
////////////////////
// fetch queue
// circular fifo of fetch packets toward dispatch
////////////////////

`timescale 1ns/1ps

module fetch_queue (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     push,
  input  fetch_pkg::fetch_packet_t push_packet,
  input  logic                     flush,          // redirect, empties the queue
  input  logic                     dispatch_ready,
  output logic                     queue_space,    // room for two more
  output logic                     out_valid,
  output fetch_pkg::fetch_packet_t out_packet
);

  fetch_pkg::fetch_packet_t mem [fetch_pkg::queue_depth];

  logic [fetch_pkg::queue_ptr_bits-1:0]   rd_ptr;
  logic [fetch_pkg::queue_ptr_bits-1:0]   wr_ptr;
  logic [fetch_pkg::queue_count_bits-1:0] count;
  logic                                   pop;

  assign out_valid   = (count != '0);
  assign out_packet  = mem[rd_ptr];                        // head, valid with out_valid
  assign pop         = out_valid & dispatch_ready;         // dispatch handshake
  assign queue_space = (count <= fetch_pkg::queue_depth - 2);

  //////////////////// pointers and count

  always_ff @(posedge clock) begin
    if (reset || flush) begin
      rd_ptr <= '0;  // flush beats a push in the same cycle
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      if (push && !pop)
        count <= count + 1'b1;
      else if (pop && !push)
        count <= count - 1'b1;
    end
  end

  // storage, write lands at the tail
  always_ff @(posedge clock) begin
    if (push && !flush)
      mem[wr_ptr] <= push_packet;
  end

endmodule

//--- logic/fetch_front.sv
////////////////////
// fetch front end top
// bus port, fetch stage, btb and fetch queue
////////////////////

`timescale 1ns/1ps

module fetch_front (
  input  logic                     clock,
  input  logic                     reset,
  input  fetch_pkg::wb_rsp_t       wb_rsp,          // from instruction memory
  input  fetch_pkg::retire_t       retire,          // one-cycle retire info
  input  logic                     dispatch_ready,
  output fetch_pkg::wb_req_t       wb_req,
  output logic                     out_valid,
  output fetch_pkg::fetch_packet_t out_packet
);

  //////////////////// internal links

  logic                            fetch_req;
  logic [fetch_pkg::xlen-1:0]      fetch_addr;
  logic                            fetch_busy;
  logic                            fetch_done;
  logic [fetch_pkg::mem_width-1:0] fetch_data;
  logic [fetch_pkg::xlen-1:0]      pc;
  logic                            push;
  fetch_pkg::fetch_packet_t        push_packet;
  logic                            flush;
  logic                            queue_space;
  fetch_pkg::btb_lookup_t          btb;

  imem_wb_port port0 (
    .clock, .reset,
    .fetch_req, .fetch_addr, .wb_rsp,
    .wb_req, .fetch_busy, .fetch_done, .fetch_data
  );

  if_stage stage0 (
    .clock, .reset,
    .fetch_busy, .fetch_done, .fetch_data, .queue_space, .btb, .retire,
    .fetch_req, .fetch_addr, .pc, .push, .push_packet, .flush
  );

  branch_target_buffer btb0 (
    .clock, .reset,
    .pc, .retire,
    .btb
  );

  fetch_queue queue0 (
    .clock, .reset,
    .push, .push_packet, .flush, .dispatch_ready,
    .queue_space, .out_valid, .out_packet
  );

endmodule

//--- sim/imem_model.sv
////////////////////
// instruction memory model
// wishbone classic slave, random wait states, fixed content rule
////////////////////

`timescale 1ns/1ps

module imem_model (
  input  logic               clock,
  input  logic               reset,
  input  fetch_pkg::wb_req_t wb_req,
  output fetch_pkg::wb_rsp_t wb_rsp
);

  localparam logic [31:0] ir_salt = 32'h1300_0000;

  logic       active;     // cycle accepted, counting wait states
  logic [1:0] wait_left;

  // word at an aligned address, low half is the instruction at adr
  function automatic logic [63:0] word_at(input logic [63:0] adr);
    logic [31:0] lo;
    lo = adr[31:0];
    return {(lo + 32'd4) ^ ir_salt, lo ^ ir_salt};
  endfunction

  initial begin
    void'($urandom(32'h32c1));  // one seed for the whole run
  end

  always @(posedge clock) begin : slave
    int unsigned waits;
    if (reset) begin
      wb_rsp.ack <= 1'b0;
      active     <= 1'b0;
      wait_left  <= 2'd0;
    end else begin
      wb_rsp.ack <= 1'b0;  // ack is a single-cycle pulse
      if (wb_req.cyc && wb_req.stb && !wb_rsp.ack) begin
        if (!active) begin
          waits = $urandom % 4;  // 0 to 3 wait states
          if (waits == 0) begin
            wb_rsp.ack <= 1'b1;
            wb_rsp.dat <= word_at(wb_req.adr);
          end else begin
            active    <= 1'b1;
            wait_left <= 2'(waits - 1);
          end
        end else if (wait_left == 2'd0) begin
          wb_rsp.ack <= 1'b1;
          wb_rsp.dat <= word_at(wb_req.adr);
          active     <= 1'b0;
        end else begin
          wait_left <= wait_left - 2'd1;
        end
      end
    end
  end

endmodule

//--- sim/fetch_front_assertions.sv
////////////////////
// fetch front end checker
// wishbone protocol and queue flush properties
////////////////////

`timescale 1ns/1ps

module fetch_front_assertions (
  input logic                     clock,
  input logic                     reset,
  input fetch_pkg::wb_req_t       wb_req,
  input fetch_pkg::wb_rsp_t       wb_rsp,
  input fetch_pkg::retire_t       retire,
  input logic                     out_valid
);

  int unsigned failures = 0;  // failed properties so far

  // strobe only inside a cycle
  stb_needs_cyc: assert property (@(posedge clock) disable iff (reset)
    wb_req.stb |-> wb_req.cyc)
    else begin
      $error("wishbone stb high without cyc");
      failures = failures + 1;
    end

  // master holds the request until the slave acks
  adr_held: assert property (@(posedge clock) disable iff (reset)
    (wb_req.stb && !wb_rsp.ack) |=> (wb_req.stb && $stable(wb_req.adr)))
    else begin
      $error("wishbone request dropped or adr changed before ack");
      failures = failures + 1;
    end

  // a mispredict empties the queue on its own edge
  flush_empties: assert property (@(posedge clock) disable iff (reset)
    (retire.branch_valid && retire.mispredict) |=> !out_valid)
    else begin
      $error("out_valid high in the cycle after a mispredict");
      failures = failures + 1;
    end

endmodule

bind fetch_front fetch_front_assertions assertions0 (
  .clock, .reset, .wb_req, .wb_rsp, .retire, .out_valid
);

//--- sim/fetch_front_tb.sv
////////////////////
// fetch front end testbench
// directed tests for fetch order, back-pressure, redirect, btb
////////////////////

`timescale 1ns/1ps

module fetch_front_tb;

  localparam logic [31:0] ir_salt     = 32'h1300_0000;
  localparam int          cycle_limit = 2000;  // tests need about 400 cycles

  logic                     clock;
  logic                     reset;
  logic                     dispatch_ready;
  fetch_pkg::retire_t       retire;
  fetch_pkg::wb_req_t       wb_req;
  fetch_pkg::wb_rsp_t       wb_rsp;
  logic                     out_valid;
  fetch_pkg::fetch_packet_t out_packet;

  logic [63:0] expect_pc;          // pc the stream must deliver next
  int unsigned cycle_count = 0;

  fetch_front dut0 (
    .clock, .reset, .wb_rsp, .retire, .dispatch_ready,
    .wb_req, .out_valid, .out_packet
  );

  imem_model mem0 (.clock, .reset, .wb_req, .wb_rsp);

  always #2 clock = ~clock;  // 4 ns period

  //////////////////// watchdog

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (dut0.assertions0.failures != 0) begin
      $display("a bus or queue assertion failed");
      $display("RESULT: FAIL");
      $fatal(1, "assertion failure");
    end else if (cycle_count >= cycle_limit) begin
      $display("timeout, no finish after %0d cycles", cycle_count);
      $display("RESULT: FAIL");
      $fatal(1, "timeout");
    end
  end

  //////////////////// helpers

  task automatic check(input string name, input logic [63:0] expected,
                       input logic [63:0] actual);
    if (expected !== actual) begin
      $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
      $display("RESULT: FAIL");
      $fatal(1, "check failed");
    end
  endtask

  // returns the packet that moves at the next handshake edge
  task automatic pop_packet(output fetch_pkg::fetch_packet_t p);
    do @(negedge clock); while (!(out_valid && dispatch_ready));
    p = out_packet;
    @(posedge clock);
  endtask

  task automatic expect_packet(input string name, input logic [63:0] npc, input logic pred);
    fetch_pkg::fetch_packet_t p;
    pop_packet(p);
    check({name, " pc"}, expect_pc, p.pc);
    check({name, " ir"}, 64'(expect_pc[31:0] ^ ir_salt), 64'(p.ir));  // content rule
    check({name, " npc"}, npc, p.npc);
    check({name, " pred_taken"}, 64'(pred), 64'(p.pred_taken));
    expect_pc = npc;
  endtask

  task automatic expect_next(input string name);
    expect_packet(name, expect_pc + 64'd4, 1'b0);  // plain sequential step
  endtask

  task automatic retire_branch(input logic taken, input logic mispredict,
                               input logic [63:0] pc, input logic [63:0] target);
    @(posedge clock);
    retire <= '{branch_valid: 1'b1, taken: taken, mispredict: mispredict,
                pc: pc, target: target};
    @(posedge clock);
    retire <= '0;  // one-cycle pulse
  endtask

  // mispredict with dispatch held so the queue is empty right after
  task automatic redirect(input string name, input logic taken,
                          input logic [63:0] pc, input logic [63:0] target,
                          input logic [63:0] resume_pc);
    dispatch_ready <= 1'b0;
    retire_branch(taken, 1'b1, pc, target);
    @(negedge clock);
    check({name, " out_valid after flush"}, 64'd0, 64'(out_valid));
    @(posedge clock);
    dispatch_ready <= 1'b1;
    expect_pc = resume_pc;
  endtask

  //////////////////// tests

  task automatic test_reset_state();
    @(negedge clock);
    check("reset out_valid", 64'd0, 64'(out_valid));
    check("reset cyc", 64'd0, 64'(wb_req.cyc));
    do @(negedge clock); while (!out_valid);
    check("reset pc", 64'd0, out_packet.pc);
    check("reset ir", 64'(ir_salt), 64'(out_packet.ir));
    check("reset npc", 64'd4, out_packet.npc);
    check("reset pred_taken", 64'd0, 64'(out_packet.pred_taken));
  endtask

  task automatic test_sequential();
    @(posedge clock);
    dispatch_ready <= 1'b1;
    repeat (10) expect_next("sequential");  // both word halves
  endtask

  task automatic test_back_pressure();
    dispatch_ready <= 1'b0;
    do @(negedge clock); while (!out_valid);
    repeat (40) begin
      @(negedge clock);
      check("back_pressure out_valid", 64'd1, 64'(out_valid));
      check("back_pressure occupancy", 64'd1,
            64'(dut0.queue0.count <= fetch_pkg::queue_depth));
    end
    @(posedge clock);
    dispatch_ready <= 1'b1;
    repeat (8) expect_next("back_pressure");  // in order with no gap or repeat
  endtask

  task automatic test_redirect();
    redirect("redirect taken", 1'b1, 64'h3f0, 64'h100, 64'h100);
    repeat (3) expect_next("redirect taken");
    redirect("redirect not taken", 1'b0, 64'h200, 64'h0, 64'h204);
    repeat (3) expect_next("redirect not taken");
  endtask

  task automatic test_btb();
    dispatch_ready <= 1'b0;
    retire_branch(1'b1, 1'b0, 64'h108, 64'h40);  // train without a redirect
    redirect("btb taken", 1'b1, 64'h3f0, 64'h100, 64'h100);
    repeat (2) expect_next("btb taken");
    expect_packet("btb taken", 64'h40, 1'b1);    // predicted jump
    expect_next("btb taken");
    dispatch_ready <= 1'b0;
    retire_branch(1'b0, 1'b0, 64'h108, 64'h0);   // entry cleared
    redirect("btb cleared", 1'b1, 64'h3f0, 64'h100, 64'h100);
    repeat (4) expect_next("btb cleared");
  endtask

  initial begin
    clock          = 1'b0;
    reset          = 1'b1;
    dispatch_ready = 1'b0;
    retire         = '0;
    expect_pc      = '0;
    repeat (4) @(posedge clock);
    reset <= 1'b0;
    test_reset_state();
    test_sequential();
    test_back_pressure();
    test_redirect();
    test_btb();
    repeat (2) @(negedge clock);
    if (dut0.assertions0.failures != 0) begin
      $display("a bus or queue assertion failed");
      $display("RESULT: FAIL");
      $fatal(1, "assertion failure");
    end else begin
      $display("RESULT: PASS");
      $finish;
    end
  end

endmodule

//--- fetch_front.f
logic/fetch_pkg.sv
logic/imem_wb_port.sv
logic/if_stage.sv
logic/branch_target_buffer.sv
logic/fetch_queue.sv
logic/fetch_front.sv
sim/imem_model.sv
sim/fetch_front_assertions.sv
sim/fetch_front_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the fetch front end testbench with verilator, run it, check the log

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module fetch_front_tb \
  -f fetch_front.f \
  --Mdir "$build_dir" -o fetch_front_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

# keep running past an assertion error so the testbench can report it
"./$build_dir/fetch_front_sim" +verilator+error+limit+100 > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^RESULT: PASS$" "$log_file"; then
  exit 0
fi
echo "pass message not found in $log_file"
exit 1
